// File: uart_core.f
uart_pkg.sv
baud_gen.sv
uart_ctrl.sv
uart_tx_shift.sv
uart_rx_shift.sv
uart_core.sv
uart_core_assert.sv
tb_uart_core.sv

// File: tb_uart_core.sv
`timescale 1ns/1ps

module tb_uart_core
  import uart_pkg::*;
();

  localparam int CPB         = 8;
  localparam int NUM_BYTES   = 20;
  localparam int NUM_FRAMES  = 2 * NUM_BYTES + 2;  // tx, rx, bad stop, glitch
  localparam int WATCHDOG_NS = (NUM_FRAMES + 4) * 10 * CPB * 4;

  logic                 clk_i = 1'b0;
  logic                 reset_i;
  logic                 rx_i;
  logic                 tx_o;
  logic [DATA_BITS-1:0] tx_data_i;
  logic                 tx_start_i;
  logic                 tx_busy_o;
  rx_result_t           rx_data_o;
  logic                 rx_valid_o;

  integer     seed = 32'h0fc1_f8bb;
  int         frame_errs = 0;
  int         rx_errs = 0;
  int         level_errs = 0;
  int         other_errs = 0;
  int         tx_seen = 0;
  int         rx_seen = 0;
  logic [9:0] tx_exp_q[$];  // frames still to appear on tx_o
  rx_result_t rx_exp_q[$];

  uart_core #(.CLKS_PER_BIT(CPB)) DUT (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rx_i       (rx_i),
    .tx_o       (tx_o),
    .tx_data_i  (tx_data_i),
    .tx_start_i (tx_start_i),
    .tx_busy_o  (tx_busy_o),
    .rx_data_o  (rx_data_o),
    .rx_valid_o (rx_valid_o)
  );

  always #2 clk_i = ~clk_i;

  // bit 0 goes on the line first
  function automatic logic [9:0] expected_frame(input logic [7:0] data);
    return {1'b1, data, 1'b0};
  endfunction

  function automatic rx_result_t expected_rx(input logic [7:0] data, input logic stop);
    rx_result_t r;
    r.data      = data;
    r.frame_err = ~stop;
    return r;
  endfunction

  task automatic check_level(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
      level_errs++;
    end
  endtask

  task automatic check_frame(input logic [9:0] got, input logic [9:0] exp);
    if (got !== exp) begin
      $display("Error at %0t: tx frame %b, expected %b", $time, got, exp);
      frame_errs++;
    end
  endtask

  task automatic check_rx(input rx_result_t got, input rx_result_t exp);
    if (got !== exp) begin
      $display("Error at %0t: rx data %h err %b, expected %h err %b", $time,
               got.data, got.frame_err, exp.data, exp.frame_err);
      rx_errs++;
    end
  endtask

  // busy lasts exactly one frame and a second start mid-frame is dropped
  task automatic send_byte(input logic [7:0] data);
    int c;
    tx_exp_q.push_back(expected_frame(data));
    tx_data_i  = data;
    tx_start_i = 1'b1;
    @(negedge clk_i);
    tx_start_i = 1'b0;
    for (c = 0; c < 10 * CPB; c++) begin
      check_level("tx_busy_o", tx_busy_o, 1'b1);
      if (c == 3 * CPB) begin
        tx_data_i  = ~data;
        tx_start_i = 1'b1;
      end else begin
        tx_start_i = 1'b0;
      end
      @(negedge clk_i);
    end
    check_level("tx_busy_o", tx_busy_o, 1'b0);
  endtask

  task automatic drive_frame(input logic [7:0] data, input logic stop);
    logic [9:0] bits;
    int         k;
    bits    = expected_frame(data);
    bits[9] = stop;
    for (k = 0; k < 10; k++) begin
      rx_i = bits[k];
      repeat (CPB) @(negedge clk_i);
    end
    rx_i = 1'b1;
  endtask

  task automatic wait_rx(input int n);
    int waited;
    waited = 0;
    @(negedge clk_i);
    while (rx_seen < n && waited < 3 * CPB) begin
      @(negedge clk_i);
      waited++;
    end
    if (rx_seen < n) begin
      $display("no rx_valid_o pulse arrived for received frame %0d", n);
      other_errs++;
    end
  endtask

  initial begin : tx_monitor
    logic [9:0] frame;
    int         k;
    forever begin
      @(negedge tx_o);
      repeat (CPB / 2) @(negedge clk_i);  // middle of the start bit
      for (k = 0; k < 10; k++) begin
        if (k > 0) repeat (CPB) @(negedge clk_i);
        frame[k] = tx_o;
      end
      tx_seen++;
      if (tx_exp_q.size() == 0) begin
        $display("a frame appeared on tx_o at %0t with no byte sent", $time);
        other_errs++;
      end else begin
        check_frame(frame, tx_exp_q.pop_front());
      end
    end
  end

  always @(negedge clk_i) begin
    if (!reset_i && rx_valid_o === 1'b1) begin
      rx_seen++;
      if (rx_exp_q.size() == 0) begin
        $display("rx_valid_o pulsed at %0t with no frame driven", $time);
        other_errs++;
      end else begin
        check_rx(rx_data_o, rx_exp_q.pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout: the test did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    logic [7:0] b;
    int         i;
    int         total;
    reset_i    = 1'b1;
    rx_i       = 1'b1;
    tx_data_i  = '0;
    tx_start_i = 1'b0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (4) begin
      check_level("tx_o", tx_o, 1'b1);
      check_level("tx_busy_o", tx_busy_o, 1'b0);
      check_level("rx_valid_o", rx_valid_o, 1'b0);
      @(negedge clk_i);
    end
    check_rx(rx_data_o, '0);
    for (i = 0; i < NUM_BYTES; i++) begin
      send_byte(8'($random(seed)));
    end
    for (i = 0; i < NUM_BYTES; i++) begin
      b = 8'($random(seed));
      rx_exp_q.push_back(expected_rx(b, 1'b1));
      drive_frame(b, 1'b1);
      wait_rx(i + 1);
    end
    b = 8'($random(seed));
    rx_exp_q.push_back(expected_rx(b, 1'b0));  // stop bit held low
    drive_frame(b, 1'b0);
    wait_rx(NUM_BYTES + 1);
    repeat (2 * CPB) @(negedge clk_i);
    rx_i = 1'b0;  // glitch under a quarter bit
    repeat (CPB / 4 - 1) @(negedge clk_i);
    rx_i = 1'b1;
    repeat (12 * CPB) @(negedge clk_i);  // long enough for a false frame to end
    if (rx_seen != NUM_BYTES + 1) begin
      $display("receiver gave %0d bytes, expected %0d", rx_seen, NUM_BYTES + 1);
      other_errs++;
    end
    if (tx_seen != NUM_BYTES || tx_exp_q.size() != 0) begin
      $display("transmitter sent %0d frames, expected %0d", tx_seen, NUM_BYTES);
      other_errs++;
    end
    total = frame_errs + rx_errs + level_errs + other_errs;
    $display("errors: frame %0d, rx %0d, level %0d, other %0d",
             frame_errs, rx_errs, level_errs, other_errs);
    if (total == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: uart_core_assert.sv
`timescale 1ns/1ps

module uart_core_assert (
  input logic clk_i,
  input logic reset_i,
  input logic tx_line_i,
  input logic tx_busy_i,
  input logic tx_start_i,
  input logic rx_valid_i
);

  // line rests high whenever no frame is going out
  a_tx_idle_high: assert property (@(posedge clk_i) disable iff (reset_i)
    !tx_busy_i |-> tx_line_i)
    else $error("tx_o low while tx_busy_o is low");

  a_rx_valid_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    rx_valid_i |=> !rx_valid_i)  // one cycle per byte
    else $error("rx_valid_o high on two consecutive cycles");

  a_busy_after_start: assert property (@(posedge clk_i) disable iff (reset_i)
    (tx_start_i && !tx_busy_i) |=> tx_busy_i)
    else $error("tx_busy_o not set after an accepted start");

endmodule

bind uart_core uart_core_assert u_assert (
  .clk_i      (clk_i),
  .reset_i    (reset_i),
  .tx_line_i  (tx_o),
  .tx_busy_i  (tx_busy_o),
  .tx_start_i (tx_start_i),
  .rx_valid_i (rx_valid_o)
);

// File: uart_core.sv
`timescale 1ns/1ps

module uart_core
  import uart_pkg::*;
#(
  parameter int CLKS_PER_BIT = 1375
) (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic                 rx_i,
  output logic                 tx_o,
  input  logic [DATA_BITS-1:0] tx_data_i,
  input  logic                 tx_start_i,
  output logic                 tx_busy_o,
  output rx_result_t           rx_data_o,
  output logic                 rx_valid_o
);

  tx_ctrl_t tx_ctrl;
  rx_ctrl_t rx_ctrl;
  logic     tx_tick;
  logic     rx_tick;
  logic     tx_restart;
  logic     rx_restart;
  logic     rx_restart_half;
  logic     rx_sync;

  uart_ctrl u_ctrl (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .tx_start_i        (tx_start_i),
    .tx_tick_i         (tx_tick),
    .rx_tick_i         (rx_tick),
    .rx_sync_i         (rx_sync),
    .tx_ctrl_o         (tx_ctrl),
    .rx_ctrl_o         (rx_ctrl),
    .tx_restart_o      (tx_restart),
    .rx_restart_o      (rx_restart),
    .rx_restart_half_o (rx_restart_half),
    .tx_busy_o         (tx_busy_o),
    .rx_done_o         (rx_valid_o)
  );

  baud_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx_baud (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .restart_i      (tx_restart),
    .restart_half_i (1'b0),  // tx always starts on a bit boundary
    .tick_o         (tx_tick)
  );

  baud_gen #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx_baud (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .restart_i      (rx_restart),
    .restart_half_i (rx_restart_half),
    .tick_o         (rx_tick)
  );

  uart_tx_shift u_tx_shift (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .tx_data_i (tx_data_i),
    .tx_ctrl_i (tx_ctrl),
    .tx_o      (tx_o)
  );

  uart_rx_shift u_rx_shift (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .rx_i      (rx_i),
    .rx_ctrl_i (rx_ctrl),
    .rx_sync_o (rx_sync),
    .rx_data_o (rx_data_o)
  );

endmodule

// File: uart_rx_shift.sv
`timescale 1ns/1ps

module uart_rx_shift
  import uart_pkg::*;
(
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       rx_i,
  input  rx_ctrl_t   rx_ctrl_i,
  output logic       rx_sync_o,
  output rx_result_t rx_data_o
);

  logic                 rx_meta_q;
  logic                 rx_sync_q;
  logic [DATA_BITS-1:0] shift_q;

  // two-flop synchronizer, idles high like the line
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_ctrl_i.clear) begin
      shift_q <= '0;
    end else if (rx_ctrl_i.sample) begin
      shift_q <= {rx_sync_q, shift_q[DATA_BITS-1:1]};  // lsb arrives first
    end
  end

  // output byte register, held until the next frame ends
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_data_o <= '0;
    end else if (rx_ctrl_i.check_stop) begin
      rx_data_o.data      <= shift_q;
      rx_data_o.frame_err <= ~rx_sync_q;  // stop must be high
    end
  end

  assign rx_sync_o = rx_sync_q;

endmodule

// File: uart_tx_shift.sv
`timescale 1ns/1ps

module uart_tx_shift
  import uart_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  logic [DATA_BITS-1:0] tx_data_i,
  input  tx_ctrl_t             tx_ctrl_i,
  output logic                 tx_o
);

  logic [DATA_BITS-1:0] shift_q;
  logic                 line_d;

  always_ff @(posedge clk_i) begin
    if (tx_ctrl_i.load) shift_q <= tx_data_i;
    else if (tx_ctrl_i.shift) shift_q <= shift_q >> 1;  // lsb first
  end

  always_comb begin
    case (tx_ctrl_i.phase)
      PH_START: line_d = 1'b0;
      // on a shift edge the next bit is still one place up
      PH_DATA:  line_d = tx_ctrl_i.shift ? shift_q[1] : shift_q[0];
      default:  line_d = 1'b1;  // idle and stop
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_o <= 1'b1;
    end else begin
      tx_o <= line_d;
    end
  end

endmodule

// File: uart_ctrl.sv
`timescale 1ns/1ps

module uart_ctrl
  import uart_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     tx_start_i,
  input  logic     tx_tick_i,
  input  logic     rx_tick_i,
  input  logic     rx_sync_i,
  output tx_ctrl_t tx_ctrl_o,
  output rx_ctrl_t rx_ctrl_o,
  output logic     tx_restart_o,
  output logic     rx_restart_o,
  output logic     rx_restart_half_o,
  output logic     tx_busy_o,
  output logic     rx_done_o
);

  localparam int BIT_W = $clog2(DATA_BITS);
  localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(DATA_BITS - 1);

  uart_phase_e      tx_phase_q;
  uart_phase_e      tx_phase_d;
  logic [BIT_W-1:0] tx_bit_q;
  logic [BIT_W-1:0] tx_bit_d;
  logic             tx_accept;

  uart_phase_e      rx_phase_q;
  uart_phase_e      rx_phase_d;
  logic [BIT_W-1:0] rx_bit_q;
  logic [BIT_W-1:0] rx_bit_d;
  logic             rx_done_q;

  assign tx_accept = (tx_phase_q == PH_IDLE) && tx_start_i;  // ignored while busy

  always_comb begin
    tx_phase_d = tx_phase_q;
    tx_bit_d   = tx_bit_q;
    case (tx_phase_q)
      PH_IDLE: if (tx_start_i) tx_phase_d = PH_START;
      PH_START: begin
        if (tx_tick_i) begin
          tx_phase_d = PH_DATA;
          tx_bit_d   = '0;
        end
      end
      PH_DATA: begin
        if (tx_tick_i) begin
          if (tx_bit_q == LAST_BIT) tx_phase_d = PH_STOP;
          else tx_bit_d = tx_bit_q + 1'b1;
        end
      end
      PH_STOP: if (tx_tick_i) tx_phase_d = PH_IDLE;
      default: tx_phase_d = PH_IDLE;
    endcase
  end

  // receiver re-checks the start bit at its middle
  always_comb begin
    rx_phase_d = rx_phase_q;
    rx_bit_d   = rx_bit_q;
    case (rx_phase_q)
      PH_IDLE: if (!rx_sync_i) rx_phase_d = PH_START;
      PH_START: begin
        if (rx_tick_i) begin
          if (rx_sync_i) begin
            rx_phase_d = PH_IDLE;  // glitch, drop it
          end else begin
            rx_phase_d = PH_DATA;
            rx_bit_d   = '0;
          end
        end
      end
      PH_DATA: begin
        if (rx_tick_i) begin
          if (rx_bit_q == LAST_BIT) rx_phase_d = PH_STOP;
          else rx_bit_d = rx_bit_q + 1'b1;
        end
      end
      PH_STOP: if (rx_tick_i) rx_phase_d = PH_IDLE;
      default: rx_phase_d = PH_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_phase_q <= PH_IDLE;
      tx_bit_q   <= '0;
      rx_phase_q <= PH_IDLE;
      rx_bit_q   <= '0;
      rx_done_q  <= 1'b0;
    end else begin
      tx_phase_q <= tx_phase_d;
      tx_bit_q   <= tx_bit_d;
      rx_phase_q <= rx_phase_d;
      rx_bit_q   <= rx_bit_d;
      rx_done_q  <= (rx_phase_q == PH_STOP) && rx_tick_i;  // same edge as byte register
    end
  end

  // shifter registers the line, so it gets the upcoming phase
  assign tx_ctrl_o.phase = tx_phase_d;
  assign tx_ctrl_o.load  = tx_accept;
  assign tx_ctrl_o.shift = (tx_phase_q == PH_DATA) && tx_tick_i;

  assign rx_ctrl_o.sample     = (rx_phase_q == PH_DATA) && rx_tick_i;
  assign rx_ctrl_o.check_stop = (rx_phase_q == PH_STOP) && rx_tick_i;
  assign rx_ctrl_o.clear      = (rx_phase_q == PH_IDLE) && !rx_sync_i;

  assign tx_restart_o      = (tx_phase_q == PH_IDLE);  // counter parked at zero
  assign rx_restart_o      = (rx_phase_q == PH_IDLE) && rx_sync_i;
  assign rx_restart_half_o = (rx_phase_q == PH_IDLE) && !rx_sync_i;  // start edge seen

  assign tx_busy_o = (tx_phase_q != PH_IDLE);
  assign rx_done_o = rx_done_q;

endmodule

// File: baud_gen.sv
`timescale 1ns/1ps

module baud_gen #(
  parameter int CLKS_PER_BIT = 1375
) (
  input  logic clk_i,
  input  logic reset_i,
  input  logic restart_i,
  input  logic restart_half_i,
  output logic tick_o
);

  localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
  localparam logic [CNT_W-1:0] LAST = CNT_W'(CLKS_PER_BIT - 1);
  localparam logic [CNT_W-1:0] HALF = CNT_W'(CLKS_PER_BIT / 2);

  logic [CNT_W-1:0] cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else if (restart_i) begin
      cnt_q <= '0;
    end else if (restart_half_i) begin
      cnt_q <= HALF;  // first tick lands mid-bit
    end else if (cnt_q == LAST) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  assign tick_o = (cnt_q == LAST);  // last cycle of the bit

endmodule

// File: uart_pkg.sv
package uart_pkg;

  localparam int DATA_BITS = 8;  // data bits per frame, lsb first

  // phase of one serial frame, shared by both directions
  typedef enum logic [1:0] {
    PH_IDLE  = 2'd0,  // line high, waiting
    PH_START = 2'd1,  // start bit
    PH_DATA  = 2'd2,  // data bits
    PH_STOP  = 2'd3   // stop bit
  } uart_phase_e;

  // control to the transmit shifter
  typedef struct packed {
    uart_phase_e phase;  // phase of the bit now going onto the line
    logic        load;   // copy host byte
    logic        shift;  // advance to next data bit
  } tx_ctrl_t;

  // control to the receive shifter
  typedef struct packed {
    logic sample;      // shift in one data bit
    logic check_stop;  // sample stop bit, finish the byte
    logic clear;       // new frame starting
  } rx_ctrl_t;

  // received byte as seen by the host
  typedef struct packed {
    logic [DATA_BITS-1:0] data;
    logic                 frame_err;  // stop bit was low
  } rx_result_t;

endpackage
